/* sim/dispatch_golden.txt */
// columns: kind _ unit or flag _ register _ data (issue data: rs1 rs2 spec imm)
// kinds: 1 instr, 2 instr held, 3 wait accept, 4 writeback, 5 branch (0 resolve, 1 miss),
// 6 ex_ready, 7 expect freeze, 8 expect issue, 9 idle, a no issue, e end test, f end
// test 1: independent instructions
1_0_00_003100b3 // add x1, x2, x3
1_0_00_04c2a283 // lw x5, 0x45(x6), base in bits 25:21
1_0_00_00838463 // beq x7, x8, +8
8_0_01_0203_0000
8_2_05_0600_0045
8_1_08_0708_0004
5_0_00_00000000
4_0_01_00000000
4_2_05_00000000
e_0_00_00000001
// test 2: read after load
1_0_00_00c02503 // lw x10, 0(x6)
1_0_00_000505b3 // add x11, x10, x0
8_2_0a_0600_0000
9_0_00_00000005
a_0_00_00000000
4_2_0a_00000000
8_0_0b_0a00_0000
4_0_0b_00000000
e_0_00_00000002
// test 3: second writer of x12
1_0_00_00500613 // addi x12, x0, 5
8_0_0c_0000_0005
2_0_00_00c02603 // lw x12, 0(x6)
7_1_00_00000000
9_0_00_00000003
7_1_00_00000000
4_0_0c_00000000
3_0_00_00000000
8_2_0c_0600_0000
4_2_0c_00000000
e_0_00_00000003
// test 4: back-pressure
6_0_00_00000000
1_0_00_002086b3 // add x13, x1, x2
2_0_00_40418733 // sub x14, x3, x4
7_1_00_00000000
9_0_00_00000004
a_0_00_00000000
6_1_00_00000000
3_0_00_00000000
8_0_0d_0102_0000
8_0_0e_0304_0000
4_0_0d_00000000
4_0_0e_00000000
e_0_00_00000004
// test 5: miss squashes speculative work
1_0_00_00839463 // bne x7, x8, +8
1_0_00_00700793 // addi x15, x0, 7
8_1_08_0708_0004
8_0_0f_0000_1007
6_0_00_00000000
1_0_00_00c02803 // lw x16, 0(x6)
5_1_00_00000000
6_1_00_00000000
9_0_00_00000005
a_0_00_00000000
2_0_00_00900813 // addi x16, x0, 9
7_0_00_00000000
3_0_00_00000000
8_0_10_0000_0009
4_0_10_00000000
e_0_00_00000005
// test 6: resolve clears spec
1_0_00_00838463 // beq x7, x8, +8
8_1_08_0708_0004
6_0_00_00000000
1_0_00_00300893 // addi x17, x0, 3
9_0_00_00000003
a_0_00_00000000
5_0_00_00000000
6_1_00_00000000
8_0_11_0000_0003
4_0_11_00000000
e_0_00_00000006
f_0_00_00000000

/* all.f */
common/dispatch_pkg.sv
common/fust_if.sv
design/instr_decode.sv
design/reg_status_table.sv
design/dispatch_ctrl.sv
fust/fust_row.sv
fust/issue_select.sv
design/dispatch_top.sv
sim/tb_dispatch.sv

/* sim/tb_dispatch.sv */
`timescale 1ns/1ps

module tb_dispatch
    import dispatch_pkg::*;
();

    localparam int DEPTH             = 256;
    localparam int CYCLES_PER_RECORD = 40;

    logic        CLK;
    logic        nRST;
    word_t       instr;
    logic        instr_valid;
    logic        freeze;
    logic        wb_en;
    reg_idx_t    wb_reg;
    fu_e         wb_fu;
    logic        branch_resolved;
    logic        branch_miss;
    logic        ex_ready;
    logic        issue_valid;
    fu_e         issue_fu;
    reg_idx_t    issue_rd;
    reg_idx_t    issue_rs1;
    reg_idx_t    issue_rs2;
    logic [11:0] issue_imm;
    logic [3:0]  issue_op;
    logic        issue_spec;

    // kind, unit or flag, register, data
    logic [47:0] golden [DEPTH];
    // expected op and issued op above the layout of an expected issue record
    logic [51:0] issued [$];
    // op of the instruction last accepted into each unit
    logic [3:0]  pending_op [NUM_FU];

    int n_records;
    int cycle_count;
    int cycle_limit;
    int accept_count;
    int accepts_at_drive;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    dispatch_top #(.NUM_FU(NUM_FU), .NUM_REGS(NUM_REGS)) UUT (
        .CLK(CLK), .nRST(nRST),
        .instr(instr), .instr_valid(instr_valid), .freeze(freeze),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_fu(wb_fu),
        .branch_resolved(branch_resolved), .branch_miss(branch_miss),
        .ex_ready(ex_ready),
        .issue_valid(issue_valid), .issue_fu(issue_fu), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .issue_op(issue_op), .issue_spec(issue_spec)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    // execution unit from the major opcode
    function automatic fu_e unit_of(input word_t word);
        case (word[6:0])
            OP_LOAD, OP_STORE:          return FU_LD_ST;
            OP_BRANCH, OP_JAL, OP_JALR: return FU_BRANCH;
            default:                    return FU_ALU;
        endcase
    endfunction

    // funct3 names the operation and bit 30 picks sub or sra
    function automatic logic [3:0] op_of(input word_t word);
        logic alt;
        alt = (word[6:0] == OP_RTYPE)
            || ((word[6:0] == OP_ITYPE) && (word[14:12] == 3'b101));
        return {alt && word[30], word[14:12]};
    endfunction

    // outputs are settled mid-cycle
    always @(negedge CLK) begin
        if (issue_valid) begin
            issued.push_back({pending_op[issue_fu], issue_op, 2'b00, issue_fu, 3'b000,
                              issue_rd, 3'b000, issue_rs1, 3'b000, issue_rs2, 3'b000,
                              issue_spec, issue_imm});
        end
        // instruction taken at the coming edge
        if (instr_valid && !freeze && !branch_miss) begin
            accept_count++;
            pending_op[unit_of(instr)] = op_of(instr);
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // pulses drop after one clock unless driven again
    task automatic tick();
        @(posedge CLK);
        wb_en           <= 1'b0;
        branch_resolved <= 1'b0;
        branch_miss     <= 1'b0;
    endtask

    task automatic drive_instr(input word_t word);
        tick();
        instr            <= word;
        instr_valid      <= 1'b1;
        accepts_at_drive  = accept_count;
    endtask

    task automatic wait_accept();
        do begin
            tick();
        end while (accept_count == accepts_at_drive);
        instr_valid <= 1'b0;
    endtask

    task automatic expect_issue(input logic [47:0] rec);
        logic [51:0] got;
        while (issued.size() == 0) begin
            tick();
        end
        got = issued.pop_front();
        check_eq("issue_fu", got[43:40], rec[43:40]);
        check_eq("issue_rd", got[39:32], rec[39:32]);
        check_eq("issue_rs1", got[31:24], rec[31:24]);
        check_eq("issue_rs2", got[23:16], rec[23:16]);
        check_eq("issue_spec", got[15:12], rec[15:12]);
        check_eq("issue_imm", got[11:0], rec[11:0]);
        check_eq("issue_op", got[47:44], got[51:48]);
    endtask

    task automatic end_test(input int id);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d passed", id);
        end else begin
            $display("test %0d failed with %0d errors", id, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic run_record(input logic [47:0] rec);
        case (rec[47:44])
            4'h1: begin
                drive_instr(rec[31:0]);
                wait_accept();
            end
            4'h2: drive_instr(rec[31:0]);
            4'h3: wait_accept();
            4'h4: begin
                tick();
                wb_en  <= 1'b1;
                wb_reg <= rec[36:32];
                wb_fu  <= fu_e'(rec[41:40]);
            end
            4'h5: begin
                tick();
                if (rec[40]) begin
                    branch_miss <= 1'b1;
                end else begin
                    branch_resolved <= 1'b1;
                end
            end
            4'h6: begin
                tick();
                ex_ready <= rec[40];
            end
            4'h7: begin
                @(negedge CLK);
                check_eq("freeze", freeze, rec[40]);
            end
            4'h8: expect_issue(rec);
            4'h9: repeat (rec[31:0]) tick();
            4'hA: begin
                tick();
                if (issued.size() != 0) begin
                    $display("an instruction issued at %0t where none should issue", $time);
                    errors++;
                    test_errors++;
                    issued.delete();
                end
            end
            4'hE: end_test(rec[31:0]);
            default: begin
                $display("golden file holds an unknown record kind %0h", rec[47:44]);
                errors++;
                test_errors++;
            end
        endcase
    endtask

    initial begin
        nRST            = 1'b0;
        instr           = '0;
        instr_valid     = 1'b0;
        wb_en           = 1'b0;
        wb_reg          = '0;
        wb_fu           = FU_ALU;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        ex_ready        = 1'b1;

        $readmemh("sim/dispatch_golden.txt", golden);
        n_records = 0;
        while (n_records < DEPTH && golden[n_records][47:44] !== 4'hF) begin
            n_records++;
        end
        if (n_records == DEPTH) begin
            $display("golden file has no end record");
            errors++;
        end
        cycle_limit = 10 + CYCLES_PER_RECORD * (n_records + 1);

        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        for (int i = 0; i < n_records; i++) begin
            run_record(golden[i]);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* design/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top
    import dispatch_pkg::*;
#(
    parameter int NUM_FU   = dispatch_pkg::NUM_FU,
    parameter int NUM_REGS = dispatch_pkg::NUM_REGS
) (
    input  logic        CLK,
    input  logic        nRST,
    input  word_t       instr,
    input  logic        instr_valid,
    output logic        freeze,
    input  logic        wb_en,
    input  reg_idx_t    wb_reg,
    input  fu_e         wb_fu,
    input  logic        branch_resolved,
    input  logic        branch_miss,
    input  logic        ex_ready,
    output logic        issue_valid,
    output fu_e         issue_fu,
    output reg_idx_t    issue_rd,
    output reg_idx_t    issue_rs1,
    output reg_idx_t    issue_rs2,
    output logic [11:0] issue_imm,
    output logic [3:0]  issue_op,
    output logic        issue_spec
);

    fu_e         dec_fu;
    reg_idx_t    dec_rd;
    reg_idx_t    dec_rs1;
    reg_idx_t    dec_rs2;
    logic [11:0] dec_imm;
    logic [3:0]  dec_op;
    logic        dec_i_type;
    logic [1:0]  dec_j_type;
    logic        dec_mem_store;
    logic        dec_reg_write;
    logic        dec_cond_branch;

    logic        rd_busy;
    tag_t        rs1_tag;
    tag_t        rs2_tag;
    logic        di_write;
    tag_t        di_tag;
    logic        di_spec;

    fust_if #(.NUM_FU(NUM_FU)) fif ();

    instr_decode u_decode (
        .instr(instr), .fu(dec_fu), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2),
        .imm(dec_imm), .op(dec_op), .i_type(dec_i_type), .j_type(dec_j_type),
        .mem_store(dec_mem_store), .reg_write(dec_reg_write),
        .is_cond_branch(dec_cond_branch)
    );

    reg_status_table #(.NUM_REGS(NUM_REGS)) u_rst (
        .CLK(CLK), .nRST(nRST),
        .di_write(di_write), .di_sel(dec_rd), .di_tag(di_tag), .di_spec(di_spec),
        .wb_write(wb_en), .wb_sel(wb_reg),
        .flush(branch_miss), .resolved(branch_resolved),
        .rd_sel(dec_rd), .rs1_sel(dec_rs1), .rs2_sel(dec_rs2),
        .rd_busy(rd_busy), .rs1_tag(rs1_tag), .rs2_tag(rs2_tag)
    );

    dispatch_ctrl u_ctrl (
        .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid),
        .fu(dec_fu), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2), .imm(dec_imm),
        .op(dec_op), .i_type(dec_i_type), .j_type(dec_j_type),
        .mem_store(dec_mem_store), .reg_write(dec_reg_write),
        .is_cond_branch(dec_cond_branch),
        .rd_busy(rd_busy), .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .wb_en(wb_en), .wb_reg(wb_reg),
        .branch_resolved(branch_resolved), .branch_miss(branch_miss),
        .fif(fif.ctrl),
        .di_write(di_write), .di_tag(di_tag), .di_spec(di_spec), .freeze(freeze)
    );

    // one status row per functional unit
    for (genvar g = 0; g < NUM_FU; g++) begin : g_row
        fust_row #(.FU_ID(g)) u_row (
            .CLK(CLK), .nRST(nRST),
            .wb_en(wb_en), .wb_reg(wb_reg), .wb_fu(wb_fu),
            .branch_resolved(branch_resolved), .branch_miss(branch_miss),
            .fif(fif.row)
        );
    end

    issue_select #(.NUM_FU(NUM_FU)) u_sel (
        .ex_ready(ex_ready), .fif(fif.sel),
        .issue_valid(issue_valid), .issue_fu(issue_fu), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .issue_op(issue_op), .issue_spec(issue_spec)
    );

endmodule

/* fust/issue_select.sv */
`timescale 1ns/1ps

module issue_select
    import dispatch_pkg::*;
#(
    parameter int NUM_FU = dispatch_pkg::NUM_FU
) (
    input  logic        ex_ready,
    fust_if.sel         fif,
    output logic        issue_valid,
    output fu_e         issue_fu,
    output reg_idx_t    issue_rd,
    output reg_idx_t    issue_rs1,
    output reg_idx_t    issue_rs2,
    output logic [11:0] issue_imm,
    output logic [3:0]  issue_op,
    output logic        issue_spec
);

    localparam int SEL_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

    logic [NUM_FU-1:0] ready;
    logic [SEL_W-1:0]  sel;
    fust_op_t          sel_op;

    // operands available in every ready row
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            ready[i] = fif.busy[i] && (fif.t1[i] == TAG_NONE) && (fif.t2[i] == TAG_NONE);
        end
    end

    // lowest index wins
    always_comb begin
        sel = '0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    assign issue_valid = ex_ready && (|ready);

    always_comb begin
        fif.grant      = '0;
        fif.grant[sel] = issue_valid;
    end

    assign sel_op     = fif.op[sel];
    assign issue_fu   = fu_e'(sel);
    assign issue_rd   = sel_op.rd;
    assign issue_rs1  = sel_op.rs1;
    assign issue_rs2  = sel_op.rs2;
    assign issue_imm  = sel_op.imm;
    assign issue_op   = sel_op.op;
    assign issue_spec = fif.spec[sel];

endmodule

/* fust/fust_row.sv */
`timescale 1ns/1ps

module fust_row
    import dispatch_pkg::*;
#(
    parameter int FU_ID = 0
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  fu_e      wb_fu,
    input  logic     branch_resolved,
    input  logic     branch_miss,
    fust_if.row      fif
);

    logic     busy_q;
    logic     spec_q;
    tag_t     t1_q;
    tag_t     t2_q;
    fust_op_t op_q;
    tag_t     wb_tag;
    logic     clr_t1;
    logic     clr_t2;
    logic     drop;

    assign wb_tag = fu_tag(wb_fu);

    // only the awaited producer clears a source
    assign clr_t1 = wb_en && busy_q && (wb_reg == op_q.rs1) && (wb_tag == t1_q);
    assign clr_t2 = wb_en && busy_q && (wb_reg == op_q.rs2) && (wb_tag == t2_q);

    // issued, or squashed by a miss
    assign drop = fif.grant[FU_ID] || (branch_miss && spec_q);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
            spec_q <= 1'b0;
            t1_q   <= TAG_NONE;
            t2_q   <= TAG_NONE;
        end else if (fif.en[FU_ID]) begin
            busy_q <= 1'b1;
            spec_q <= fif.new_spec;
            t1_q   <= fif.new_t1;
            t2_q   <= fif.new_t2;
        end else begin
            if (drop) begin
                busy_q <= 1'b0;
                spec_q <= 1'b0;
            end else if (branch_resolved) begin
                spec_q <= 1'b0;
            end

            if (clr_t1) begin
                t1_q <= TAG_NONE;
            end
            if (clr_t2) begin
                t2_q <= TAG_NONE;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fif.en[FU_ID]) begin
            op_q <= fif.new_op;
        end
    end

    assign fif.busy[FU_ID] = busy_q;
    assign fif.spec[FU_ID] = spec_q;
    assign fif.t1[FU_ID]   = t1_q;
    assign fif.t2[FU_ID]   = t2_q;
    assign fif.op[FU_ID]   = op_q;

endmodule

/* design/dispatch_ctrl.sv */
`timescale 1ns/1ps

module dispatch_ctrl
    import dispatch_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        instr_valid,
    input  fu_e         fu,
    input  reg_idx_t    rd,
    input  reg_idx_t    rs1,
    input  reg_idx_t    rs2,
    input  logic [11:0] imm,
    input  logic [3:0]  op,
    input  logic        i_type,
    input  logic [1:0]  j_type,
    input  logic        mem_store,
    input  logic        reg_write,
    input  logic        is_cond_branch,
    input  logic        rd_busy,
    input  tag_t        rs1_tag,
    input  tag_t        rs2_tag,
    input  logic        wb_en,
    input  reg_idx_t    wb_reg,
    input  logic        branch_resolved,
    input  logic        branch_miss,
    fust_if.ctrl        fif,
    output logic        di_write,
    output tag_t        di_tag,
    output logic        di_spec,
    output logic        freeze
);

    logic struct_hazard;
    logic waw_hazard;
    logic accept;
    logic spec;
    logic spec_next;

    // target row still occupied
    assign struct_hazard = fif.busy[fu];
    assign waw_hazard    = reg_write && rd_busy;

    assign freeze = instr_valid && (struct_hazard || waw_hazard);
    assign accept = instr_valid && !freeze && !branch_miss;

    always_comb begin
        fif.en     = '0;
        fif.en[fu] = accept;
    end

    always_comb begin
        fif.new_op.rd        = rd;
        fif.new_op.rs1       = rs1;
        fif.new_op.rs2       = rs2;
        fif.new_op.imm       = imm;
        fif.new_op.op        = op;
        fif.new_op.i_type    = i_type;
        fif.new_op.j_type    = j_type;
        fif.new_op.mem_store = mem_store;
    end

    // a source completing this cycle is already available
    assign fif.new_t1 = (wb_en && (wb_reg == rs1)) ? TAG_NONE : rs1_tag;
    assign fif.new_t2 = (wb_en && (wb_reg == rs2)) ? TAG_NONE : rs2_tag;

    // speculative while a conditional branch is outstanding
    always_comb begin
        spec_next = spec;
        if (accept && is_cond_branch) begin
            spec_next = 1'b1;
        end else if (branch_resolved || branch_miss) begin
            spec_next = 1'b0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec <= 1'b0;
        end else begin
            spec <= spec_next;
        end
    end

    // the branch itself takes the state from before it
    assign fif.new_spec = spec && !(branch_resolved || branch_miss);

    assign di_write = accept && reg_write;
    assign di_tag   = fu_tag(fu);
    assign di_spec  = fif.new_spec;

endmodule

/* design/reg_status_table.sv */
`timescale 1ns/1ps

module reg_status_table
    import dispatch_pkg::*;
#(
    parameter int NUM_REGS = dispatch_pkg::NUM_REGS
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     di_write,
    input  reg_idx_t di_sel,
    input  tag_t     di_tag,
    input  logic     di_spec,
    input  logic     wb_write,
    input  reg_idx_t wb_sel,
    input  logic     flush,
    input  logic     resolved,
    input  reg_idx_t rd_sel,
    input  reg_idx_t rs1_sel,
    input  reg_idx_t rs2_sel,
    output logic     rd_busy,
    output tag_t     rs1_tag,
    output tag_t     rs2_tag
);

    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] spec;
    tag_t                tag [NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            spec <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                tag[i] <= TAG_NONE;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                // squash entries written behind a mispredicted branch
                if (flush && spec[i]) begin
                    busy[i] <= 1'b0;
                    spec[i] <= 1'b0;
                    tag[i]  <= TAG_NONE;
                end else if (resolved) begin
                    spec[i] <= 1'b0;
                end

                if (wb_write && (wb_sel == reg_idx_t'(i))) begin
                    busy[i] <= 1'b0;
                    spec[i] <= 1'b0;
                    tag[i]  <= TAG_NONE;
                end

                // x0 is never pending
                if (di_write && (di_sel == reg_idx_t'(i)) && (i != 0)) begin
                    busy[i] <= 1'b1;
                    spec[i] <= di_spec;
                    tag[i]  <= di_tag;
                end
            end
        end
    end

    assign rd_busy = busy[rd_sel];
    assign rs1_tag = tag[rs1_sel];
    assign rs2_tag = tag[rs2_sel];

endmodule

/* design/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
    import dispatch_pkg::*;
(
    input  word_t       instr,
    output fu_e         fu,
    output reg_idx_t    rd,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output logic [11:0] imm,
    output logic [3:0]  op,
    output logic        i_type,
    output logic [1:0]  j_type,
    output logic        mem_store,
    output logic        reg_write,
    output logic        is_cond_branch
);

    instr_u iw;

    assign iw = instr;

    always_comb begin
        fu             = FU_ALU;
        rd             = iw.arith.rd;
        rs1            = iw.arith.rs1;
        rs2            = iw.arith.rs2;
        imm            = '0;
        op             = {1'b0, iw.arith.funct3};
        i_type         = 1'b0;
        j_type         = 2'd0;
        mem_store      = 1'b0;
        reg_write      = 1'b0;
        is_cond_branch = 1'b0;

        // unused source fields go to x0 so they never pick up a tag
        case (iw.arith.opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                op        = {iw.arith.funct7[5], iw.arith.funct3};
            end
            OP_ITYPE: begin
                reg_write = 1'b1;
                i_type    = 1'b1;
                rs2       = '0;
                imm       = {iw.arith.funct7, iw.arith.rs2};
                // srai shares funct3 with srli
                if (iw.arith.funct3 == 3'b101) begin
                    op = {iw.arith.funct7[5], iw.arith.funct3};
                end
            end
            OP_LOAD: begin
                fu        = FU_LD_ST;
                reg_write = 1'b1;
                i_type    = 1'b1;
                rs1       = iw.ldst.rs1;
                rs2       = '0;
                imm       = {iw.ldst.off_hi, iw.ldst.off_lo};
            end
            OP_STORE: begin
                fu        = FU_LD_ST;
                mem_store = 1'b1;
                rs1       = iw.ldst.rs1;
                rs2       = iw.ldst.rd;
                imm       = {iw.ldst.off_hi, iw.ldst.off_lo};
            end
            OP_BRANCH: begin
                fu             = FU_BRANCH;
                is_cond_branch = 1'b1;
                imm = {iw.arith.funct7[6], iw.arith.rd[0], iw.arith.funct7[5:0],
                       iw.arith.rd[4:1]};
            end
            OP_JAL: begin
                fu        = FU_BRANCH;
                reg_write = 1'b1;
                j_type    = 2'd1;
                rs1       = '0;
                rs2       = '0;
                // upper 12 bits of the jump offset only
                imm       = {iw.arith.funct7, iw.arith.rs2};
            end
            OP_JALR: begin
                fu        = FU_BRANCH;
                reg_write = 1'b1;
                i_type    = 1'b1;
                j_type    = 2'd2;
                rs2       = '0;
                imm       = {iw.arith.funct7, iw.arith.rs2};
            end
            default: begin
                rs1 = '0;
                rs2 = '0;
            end
        endcase
    end

endmodule

/* common/fust_if.sv */
`timescale 1ns/1ps

interface fust_if
    import dispatch_pkg::*;
#(
    parameter int NUM_FU = dispatch_pkg::NUM_FU
);

    // new row contents from dispatch
    logic [NUM_FU-1:0] en;
    fust_op_t          new_op;
    tag_t              new_t1;
    tag_t              new_t2;
    logic              new_spec;

    // per-row state
    logic [NUM_FU-1:0] busy;
    tag_t              t1 [NUM_FU];
    tag_t              t2 [NUM_FU];
    fust_op_t          op [NUM_FU];
    logic [NUM_FU-1:0] spec;
    logic [NUM_FU-1:0] grant;

    modport ctrl (output en, new_op, new_t1, new_t2, new_spec, input busy);
    modport row (input en, new_op, new_t1, new_t2, new_spec, grant,
                 output busy, t1, t2, op, spec);
    modport sel (input busy, t1, t2, op, spec, output grant);

endinterface

/* common/dispatch_pkg.sv */
package dispatch_pkg;

    localparam int WORD_W   = 32;
    localparam int NUM_REGS = 32;
    localparam int NUM_FU   = 3;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        reg_idx_t;

    // functional unit doubles as the row index
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_BRANCH = 2'd1,
        FU_LD_ST  = 2'd2
    } fu_e;

    // producing unit of a pending register value
    typedef enum logic [1:0] {
        TAG_NONE   = 2'd0,
        TAG_ALU    = 2'd1,
        TAG_BRANCH = 2'd2,
        TAG_LD_ST  = 2'd3
    } tag_t;

    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } arith_fmt_t;

    // base register of the load/store layout sits one bit higher
    // stores carry their data register in the rd slot
    typedef struct packed {
        logic [5:0] off_hi;
        reg_idx_t   rs1;
        logic [5:0] off_lo;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } ldst_fmt_t;

    typedef union packed {
        arith_fmt_t arith;
        ldst_fmt_t  ldst;
    } instr_u;

    // payload held by a status row
    typedef struct packed {
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [11:0] imm;
        logic [3:0] op;
        logic       i_type;
        logic [1:0] j_type;
        logic       mem_store;
    } fust_op_t;

    function automatic tag_t fu_tag(input fu_e fu);
        case (fu)
            FU_ALU:    return TAG_ALU;
            FU_BRANCH: return TAG_BRANCH;
            FU_LD_ST:  return TAG_LD_ST;
            default:   return TAG_NONE;
        endcase
    endfunction

endpackage
